// File: verilog/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// ##########################################################################
// core widths
// ##########################################################################

// signed data word, registers and alu
`define CPU_DATA_W      16

// word program counter, 4k words
`define CPU_PC_W        12

// register file depth
`define CPU_REG_CNT     16

// ##########################################################################
// memory side
// ##########################################################################

// byte address on inst_addr / data_addr
`define CPU_BADDR_W     16

// word 0 sits at this byte address
`define CPU_MEM_OFFSET  16'h1000

`endif

// File: verilog/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    // ######################################################################
    // vectors
    // ######################################################################

    typedef logic signed [`CPU_DATA_W-1:0]         word_t;     // register value
    typedef logic [`CPU_PC_W-1:0]                  pc_t;       // word address
    typedef logic [$clog2(`CPU_REG_CNT)-1:0]       reg_idx_t;  // rs / rt / rd
    typedef logic [`CPU_BADDR_W-1:0]               baddr_t;    // memory byte address
    typedef logic [4:0]                            imm_t;      // i-type immediate

    // ######################################################################
    // encodings
    // ######################################################################

    // inst[15:13], 6 and 7 unused
    typedef enum logic [2:0] {
        OP_ADDSUB = 3'd0,   // func 1 add, 0 sub
        OP_MULSLT = 3'd1,   // func 1 slt, 0 mult
        OP_STORE  = 3'd2,
        OP_LOAD   = 3'd3,
        OP_JUMP   = 3'd4,
        OP_BEQ    = 3'd5
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_MUL = 2'd2,
        ALU_SLT = 2'd3
    } alu_op_e;

    // one instruction per trip round the loop
    typedef enum logic [3:0] {
        S_FETCH_REQ, S_FETCH_WAIT, S_DECODE, S_EXECUTE, S_MULT_DELAY,
        S_MEM_REQ, S_MEM_WAIT, S_WB_REG, S_UPDATE_PC
    } ctrl_state_e;

endpackage

// File: verilog/alu.sv
`include "cpu_params.svh"

module alu import cpu_pkg::*; (
    input  logic    clk,
    input  word_t   alu_a,
    input  word_t   alu_b,
    input  alu_op_e alu_op,
    output word_t   alu_z       // registered
);

    logic  sub;         // sub and slt share the adder
    word_t addsub_z;
    word_t mult_q;      // first multiply stage

    // ######################################################################
    // shared adder
    // ######################################################################

    assign sub      = (alu_op == ALU_SUB) || (alu_op == ALU_SLT);
    assign addsub_z = alu_a + (sub ? ~alu_b : alu_b) + word_t'(sub);   // a - b = a + ~b + 1

    // ######################################################################
    // two stage multiply
    // ######################################################################

    // low half only, same for signed and unsigned
    always_ff @(posedge clk) begin
        mult_q <= word_t'(alu_a * alu_b);
    end

    // output register
    always_ff @(posedge clk) begin
        case (alu_op)
            ALU_MUL: alu_z <= mult_q;
            ALU_SLT: alu_z <= word_t'(addsub_z[`CPU_DATA_W-1]);   // sign of a - b
            default: alu_z <= addsub_z;                           // add, sub
        endcase
    end

endmodule

// File: verilog/reg_file.sv
`include "cpu_params.svh"

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    // read ports
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_val,
    output word_t    rt_val,
    // write port
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [`CPU_REG_CNT];     // r0..r15, r0 is writable too

    // single write port, written in wb_reg
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            regs <= '{default: '0};
        else if (wr_en)
            regs[wr_idx] <= wr_data;
    end

    // reads are combinational
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

    // decoded index from a fetched word, must be known when used
    a_wr_idx_known: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_idx));

endmodule

// File: verilog/mem_bridge.sv
`include "cpu_params.svh"

module mem_bridge import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    // from ctrl
    input  logic   fetch_go,
    input  logic   load_go,
    input  logic   store_go,
    input  pc_t    pc,
    input  word_t  ls_addr,     // word address
    input  word_t  st_data,
    output logic   mem_done,
    output word_t  mem_rdata,
    // instruction memory
    output logic   inst_rd,
    output baddr_t inst_addr,
    input  logic   inst_valid,
    input  word_t  inst_rdata,
    // data memory
    output logic   data_rd,
    output logic   data_wr,
    output baddr_t data_addr,
    output word_t  data_wdata,
    input  logic   data_valid,
    input  word_t  data_rdata
);

    logic req_open;     // strobe sent, valid not back yet
    logic load_open;    // open request is a data read
    logic any_go;
    logic any_valid;

    assign any_go    = fetch_go | load_go | store_go;
    assign any_valid = req_open & (inst_valid | data_valid);

    // ######################################################################
    // strobes and request tracking
    // ######################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_rd   <= 1'b0;
            data_rd   <= 1'b0;
            data_wr   <= 1'b0;
            mem_done  <= 1'b0;
            req_open  <= 1'b0;
            load_open <= 1'b0;
        end else begin
            inst_rd  <= fetch_go;       // go + 1
            data_rd  <= load_go;
            data_wr  <= store_go;
            mem_done <= any_valid;      // valid + 1
            if (any_go) begin
                req_open  <= 1'b1;
                load_open <= load_go;
            end else if (any_valid) begin
                req_open  <= 1'b0;
                load_open <= 1'b0;
            end
        end
    end

    // address and data, held until the next go
    always_ff @(posedge clk) begin
        if (fetch_go)
            inst_addr <= baddr_t'({pc, 1'b0}) + `CPU_MEM_OFFSET;  // word * 2 + offset
        if (load_go || store_go)
            data_addr <= (baddr_t'(ls_addr) << 1) + `CPU_MEM_OFFSET;
        if (store_go)
            data_wdata <= st_data;
        // last read data, kept for decode / wb
        if (req_open && inst_valid)
            mem_rdata <= inst_rdata;
        else if (load_open && data_valid)
            mem_rdata <= data_rdata;
    end

    a_strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({inst_rd, data_rd, data_wr}));

    // ctrl must wait for mem_done before the next request
    a_single_open: assert property (@(posedge clk) disable iff (!rst_n)
        any_go |-> !req_open);

endmodule

// File: verilog/cpu_ctrl.sv
`include "cpu_params.svh"

module cpu_ctrl import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    output logic     IO_stall,
    // memory requests
    output logic     fetch_go,
    output logic     load_go,
    output logic     store_go,
    output pc_t      pc,
    output word_t    ls_addr,     // word address
    output word_t    st_data,
    input  logic     mem_done,
    input  word_t    mem_rdata,
    // register file
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    input  word_t    rs_val,
    input  word_t    rt_val,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output word_t    wr_data,
    // alu
    output word_t    alu_a,
    output word_t    alu_b,
    output alu_op_e  alu_op,
    input  word_t    alu_z
);

    ctrl_state_e state, next_state;
    word_t       ir;            // fetched instruction
    opcode_e     opcode;
    reg_idx_t    rs, rt, rd;
    logic        func;
    imm_t        imm;
    word_t       imm_ext;
    baddr_t      jump_baddr;    // jump target, byte address
    logic        beq_taken;

    // ######################################################################
    // state machine
    // ######################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state <= S_FETCH_REQ;   // first fetch right after reset
        else        state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            S_FETCH_REQ:  next_state = S_FETCH_WAIT;
            S_FETCH_WAIT: if (mem_done) next_state = S_DECODE;
            S_DECODE: begin
                case (opcode)
                    OP_ADDSUB, OP_MULSLT, OP_STORE, OP_LOAD: next_state = S_EXECUTE;
                    default: next_state = S_UPDATE_PC;  // beq, jump, no-op 6/7
                endcase
            end
            S_EXECUTE: begin
                case (opcode)
                    OP_ADDSUB: next_state = S_WB_REG;
                    OP_MULSLT: next_state = func ? S_WB_REG : S_MULT_DELAY; // mult 2 cycles
                    default:   next_state = S_MEM_REQ;                      // load, store
                endcase
            end
            S_MULT_DELAY: next_state = S_WB_REG;
            S_MEM_REQ:    next_state = S_MEM_WAIT;
            S_MEM_WAIT: begin
                if (mem_done) next_state = (opcode == OP_LOAD) ? S_WB_REG : S_UPDATE_PC;
            end
            S_WB_REG:     next_state = S_UPDATE_PC;
            S_UPDATE_PC:  next_state = S_FETCH_REQ;
            default:      next_state = S_FETCH_REQ;
        endcase
    end

    // instruction register, loaded when the fetch returns
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)                                 ir <= '0;
        else if (state == S_FETCH_WAIT && mem_done) ir <= mem_rdata;
    end

    // ######################################################################
    // decode
    // ######################################################################

    always_comb begin
        opcode     = opcode_e'(ir[15:13]);
        rs         = ir[12:9];
        rt         = ir[8:5];
        rd         = ir[4:1];
        func       = ir[0];
        imm        = ir[4:0];
        imm_ext    = {{(`CPU_DATA_W-$bits(imm_t)){imm[4]}}, imm};   // sign extend
        jump_baddr = baddr_t'(ir[12:0]);
    end

    assign beq_taken = (opcode == OP_BEQ) && (rs_val == rt_val);

    // alu op and operand b
    always_comb begin
        case (opcode)
            OP_ADDSUB: alu_op = func ? ALU_ADD : ALU_SUB;
            OP_MULSLT: alu_op = func ? ALU_SLT : ALU_MUL;
            default:   alu_op = ALU_ADD;    // rs + imm for load / store
        endcase
    end

    assign alu_a = rs_val;
    assign alu_b = (opcode == OP_ADDSUB || opcode == OP_MULSLT) ? rt_val : imm_ext;

    assign rs_idx = rs;
    assign rt_idx = rt;

    // ######################################################################
    // pc and write back
    // ######################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (state == S_UPDATE_PC) begin
            if (beq_taken)
                pc <= pc + pc_t'(1) + pc_t'(imm_ext);
            else if (opcode == OP_JUMP)
                pc <= pc_t'((jump_baddr - `CPU_MEM_OFFSET) >> 1);
            else
                pc <= pc + pc_t'(1);
        end
    end

    assign wr_en   = (state == S_WB_REG);
    assign wr_idx  = (opcode == OP_LOAD) ? rt : rd;             // load into rt, r-type into rd
    assign wr_data = (opcode == OP_LOAD) ? mem_rdata : alu_z;

    // request pulses, one cycle each
    assign fetch_go = (state == S_FETCH_REQ);
    assign load_go  = (state == S_MEM_REQ) && (opcode == OP_LOAD);
    assign store_go = (state == S_MEM_REQ) && (opcode == OP_STORE);
    assign ls_addr  = alu_z;      // rs + imm from execute
    assign st_data  = rt_val;

    // retire marker, low the cycle after update_pc
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) IO_stall <= 1'b1;
        else        IO_stall <= (state != S_UPDATE_PC);
    end

    // a retire is always followed by a fetch
    a_stall_single: assert property (@(posedge clk) disable iff (!rst_n)
        !IO_stall |=> IO_stall);

endmodule

// File: verilog/cpu_core.sv
`include "cpu_params.svh"

module cpu_core import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    output logic   IO_stall,      // low one cycle per retired instruction
    // instruction port
    output logic   inst_rd,
    output baddr_t inst_addr,
    input  logic   inst_valid,
    input  word_t  inst_rdata,
    // data port
    output logic   data_rd,
    output logic   data_wr,
    output baddr_t data_addr,
    output word_t  data_wdata,
    input  logic   data_valid,
    input  word_t  data_rdata
);

    // ctrl <-> bridge
    logic     fetch_go, load_go, store_go;
    pc_t      pc;
    word_t    ls_addr, st_data;
    logic     mem_done;
    word_t    mem_rdata;
    // ctrl <-> regs
    reg_idx_t rs_idx, rt_idx, wr_idx;
    word_t    rs_val, rt_val, wr_data;
    logic     wr_en;
    // ctrl <-> alu
    word_t    alu_a, alu_b, alu_z;
    alu_op_e  alu_op;

    cpu_ctrl ctrl0 (
        .clk(clk), .rst_n(rst_n), .IO_stall(IO_stall),
        .fetch_go(fetch_go), .load_go(load_go), .store_go(store_go),
        .pc(pc), .ls_addr(ls_addr), .st_data(st_data),
        .mem_done(mem_done), .mem_rdata(mem_rdata),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .rs_val(rs_val), .rt_val(rt_val),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_z(alu_z)
    );

    reg_file regs0 (
        .clk(clk), .rst_n(rst_n),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .rs_val(rs_val), .rt_val(rt_val),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    alu alu0 (.clk(clk), .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_z(alu_z));

    mem_bridge bridge0 (
        .clk(clk), .rst_n(rst_n),
        .fetch_go(fetch_go), .load_go(load_go), .store_go(store_go),
        .pc(pc), .ls_addr(ls_addr), .st_data(st_data),
        .mem_done(mem_done), .mem_rdata(mem_rdata),
        .inst_rd(inst_rd), .inst_addr(inst_addr),
        .inst_valid(inst_valid), .inst_rdata(inst_rdata),
        .data_rd(data_rd), .data_wr(data_wr), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_valid(data_valid), .data_rdata(data_rdata)
    );

endmodule

// File: verification/tb_cpu_core.sv
`include "cpu_params.svh"

module tb_cpu_core import cpu_pkg::*; ();

    localparam int INSTR_WORST = 20;    // fetch and data access both at the longest delay
    localparam int TEST_SETUP  = 8;     // reset plus first fetch
    localparam int TOTAL_INSTR = 31;    // 6 + 8 + 6 + 11 retired instructions
    localparam int NUM_TESTS   = 4;
    localparam int CYCLE_LIMIT = 2 * (TOTAL_INSTR * INSTR_WORST + NUM_TESTS * TEST_SETUP);

    logic   clk, rst_n, IO_stall;
    logic   inst_rd, inst_valid, data_rd, data_wr, data_valid;
    baddr_t inst_addr, data_addr;
    word_t  inst_rdata, data_wdata, data_rdata;

    word_t  imem [0:65535];     // both indexed by byte address
    word_t  dmem [0:65535];
    baddr_t fetch_log [$];
    baddr_t wr_addr_log [$];
    word_t  wr_data_log [$];
    baddr_t exp_addr_q [$];
    word_t  exp_data_q [$];
    int     retire_cnt, cycle_cnt;
    int     wait_left;          // cycles to the valid pulse or 0 when idle
    logic   open_is_fetch;
    baddr_t open_addr;
    logic [31:0] lfsr;

    cpu_core dut0 (
        .clk(clk), .rst_n(rst_n), .IO_stall(IO_stall),
        .inst_rd(inst_rd), .inst_addr(inst_addr),
        .inst_valid(inst_valid), .inst_rdata(inst_rdata),
        .data_rd(data_rd), .data_wr(data_wr), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_valid(data_valid), .data_rdata(data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ########################################################################
    // helpers
    // ########################################################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois form with taps 32 22 2 1
    endfunction

    // two lfsr bits give 1..4 cycles
    task automatic pick_delay(output int d);
        logic b0, b1;
        b0   = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1   = lfsr[0];
        lfsr = lfsr_next(lfsr);
        d    = 1 + int'({b1, b0});
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input baddr_t got, input baddr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    function automatic baddr_t word_to_baddr(input int w);
        return baddr_t'(w * 2 + `CPU_MEM_OFFSET);    // word * 2 + offset that wraps below 0x1000
    endfunction

    function automatic word_t enc_r(input logic [2:0] op, input int rs, input int rt,
                                    input int rd, input logic f);
        return {op, rs[3:0], rt[3:0], rd[3:0], f};
    endfunction

    function automatic word_t enc_i(input logic [2:0] op, input int rs, input int rt,
                                    input int imm);
        return {op, rs[3:0], rt[3:0], imm[4:0]};
    endfunction

    function automatic word_t enc_jump(input baddr_t target);
        return {OP_JUMP, target[12:0]};    // target as a byte address
    endfunction

    task automatic put_inst(input int idx, input word_t w);
        imem[word_to_baddr(idx)] = w;
    endtask

    task automatic put_data(input int idx, input word_t d);
        dmem[word_to_baddr(idx)] = d;
    endtask

    task automatic expect_write(input baddr_t a, input word_t d);
        exp_addr_q.push_back(a);
        exp_data_q.push_back(d);
    endtask

    // ########################################################################
    // memory model and monitor sampled 2 units after the edge
    // ########################################################################

    initial begin
        inst_valid = 1'b0;
        inst_rdata = '0;
        data_valid = 1'b0;
        data_rdata = '0;
        forever begin
            @(posedge clk);
            #2;
            cycle_cnt++;
            if (cycle_cnt > CYCLE_LIMIT)
                stop_run("timeout, cycle limit reached before the tests finished");
            inst_valid = 1'b0;
            data_valid = 1'b0;
            if (!rst_n) begin
                wait_left = 0;                      // drop any open request
            end else begin
                if (!IO_stall) retire_cnt++;
                if (int'(inst_rd) + int'(data_rd) + int'(data_wr) > 1)
                    stop_run("more than one memory strobe high in the same cycle");
                if ((inst_rd || data_rd || data_wr) && wait_left > 0)
                    stop_run("new memory request while another one is still open");
                if (wait_left > 0) begin
                    wait_left--;
                    if (wait_left == 0 && open_is_fetch) begin
                        inst_valid = 1'b1;
                        inst_rdata = imem[open_addr];
                    end else if (wait_left == 0) begin
                        data_valid = 1'b1;          // read data or write done
                        data_rdata = dmem[open_addr];
                    end
                end
                if (inst_rd || data_rd || data_wr) begin
                    pick_delay(wait_left);
                    open_is_fetch = inst_rd;
                    open_addr     = inst_rd ? inst_addr : data_addr;
                    if (inst_rd) fetch_log.push_back(inst_addr);
                    if (data_wr) begin
                        dmem[data_addr] = data_wdata;
                        wr_addr_log.push_back(data_addr);
                        wr_data_log.push_back(data_wdata);
                    end
                end
            end
        end
    end

    // ########################################################################
    // test sequencing
    // ########################################################################

    // reset for 2 cycles then refill memories while it is still held
    task automatic hold_reset();
        int a;
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #2;
        end
        for (a = 0; a < 65536; a++) begin
            imem[baddr_t'(a)] = word_t'({3'b111, 13'(a ^ (a >> 3))});  // opcode 7 no-op
            dmem[baddr_t'(a)] = word_t'(a ^ 32'hc3a5);
        end
        fetch_log.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        retire_cnt = 0;
    endtask

    task automatic release_reset();
        if (IO_stall !== 1'b1) stop_run("IO_stall is not high while reset is held");
        if ({inst_rd, data_rd, data_wr} !== 3'b000)
            stop_run("a memory strobe is high while reset is held");
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        if (inst_rd !== 1'b1) stop_run("first fetch not issued in the cycle after reset");
        check_addr("inst_addr", inst_addr, `CPU_MEM_OFFSET);
    endtask

    // one IO_stall pulse per fetched instruction
    task automatic run_until(input int n);
        while (retire_cnt < n) @(posedge clk);
        if (fetch_log.size() != n)
            stop_run($sformatf("%0d fetches seen for %0d retired instructions",
                               fetch_log.size(), n));
    endtask

    task automatic check_writes();
        if (wr_addr_log.size() != exp_addr_q.size())
            stop_run($sformatf("%0d stores seen, %0d expected",
                               wr_addr_log.size(), exp_addr_q.size()));
        foreach (exp_addr_q[i]) begin
            check_addr("data_addr", wr_addr_log[i], exp_addr_q[i]);
            check_word("data_wdata", wr_data_log[i], exp_data_q[i]);
        end
    endtask

    // ########################################################################
    // directed tests
    // ########################################################################

    task automatic add_sub_program();
        word_t a, b;
        a = 16'h5a31;
        b = 16'hc7f2;                                   // negative so the sum wraps
        hold_reset();
        put_data(10, a);
        put_data(11, b);
        put_inst(0, enc_i(OP_LOAD, 0, 1, 10));
        put_inst(1, enc_i(OP_LOAD, 0, 2, 11));
        put_inst(2, enc_r(OP_ADDSUB, 1, 2, 3, 1'b1));   // r3 = r1 + r2
        put_inst(3, enc_r(OP_ADDSUB, 1, 2, 4, 1'b0));   // r4 = r1 - r2
        put_inst(4, enc_i(OP_STORE, 0, 3, 12));
        put_inst(5, enc_i(OP_STORE, 0, 4, 13));
        expect_write(word_to_baddr(12), a + b);
        expect_write(word_to_baddr(13), a - b);
        release_reset();
        run_until(6);
        check_writes();
    endtask

    task automatic mult_slt_program();
        word_t a, b, d_ab, d_ba;
        a    = -16'sd300;
        b    = 16'sd217;
        d_ab = a - b;
        d_ba = b - a;
        hold_reset();
        put_data(2, a);
        put_data(3, b);
        put_inst(0, enc_i(OP_LOAD, 0, 1, 2));
        put_inst(1, enc_i(OP_LOAD, 0, 2, 3));
        put_inst(2, enc_r(OP_MULSLT, 1, 2, 3, 1'b0));   // mult
        put_inst(3, enc_r(OP_MULSLT, 1, 2, 4, 1'b1));   // slt r1, r2
        put_inst(4, enc_r(OP_MULSLT, 2, 1, 5, 1'b1));   // slt r2, r1
        put_inst(5, enc_i(OP_STORE, 0, 3, 4));
        put_inst(6, enc_i(OP_STORE, 0, 4, 5));
        put_inst(7, enc_i(OP_STORE, 0, 5, 6));
        expect_write(word_to_baddr(4), word_t'(int'(a) * int'(b)));   // low half
        expect_write(word_to_baddr(5), word_t'(d_ab[15]));
        expect_write(word_to_baddr(6), word_t'(d_ba[15]));
        release_reset();
        run_until(8);
        check_writes();
    endtask

    task automatic neg_imm_program();
        hold_reset();
        put_data(5, 16'sd20);                           // base for r1
        put_data(17, 16'h2b6e);
        put_data(-2, 16'h9e07);                         // below the 0x1000 window
        put_inst(0, enc_i(OP_LOAD, 0, 1, 5));
        put_inst(1, enc_i(OP_LOAD, 1, 2, -3));
        put_inst(2, enc_i(OP_STORE, 1, 2, -16));
        put_inst(3, enc_i(OP_STORE, 1, 1, -1));
        put_inst(4, enc_i(OP_LOAD, 0, 3, -2));
        put_inst(5, enc_i(OP_STORE, 0, 3, -5));
        expect_write(word_to_baddr(20 - 16), 16'h2b6e);
        expect_write(word_to_baddr(20 - 1), 16'sd20);
        expect_write(word_to_baddr(0 - 5), 16'h9e07);
        release_reset();
        run_until(6);
        check_writes();
    endtask

    task automatic branch_jump_program();
        int exp_pc [11] = '{0, 1, 2, 6, 7, 12, 8, 9, 10, 14, 15};
        hold_reset();
        put_data(1, 16'sd7);
        put_data(2, 16'sd7);
        put_inst(0, enc_i(OP_LOAD, 0, 1, 1));
        put_inst(1, enc_i(OP_LOAD, 0, 2, 2));
        put_inst(2, enc_i(OP_BEQ, 1, 2, 3));            // taken to 2 + 1 + 3
        put_inst(6, enc_i(OP_BEQ, 1, 0, 4));            // not taken
        put_inst(7, enc_jump(word_to_baddr(12)));
        put_inst(12, enc_i(OP_BEQ, 0, 0, -5));          // taken backwards to 8
        put_inst(8, enc_r(OP_ADDSUB, 1, 2, 3, 1'b1));
        put_inst(9, enc_i(OP_STORE, 0, 3, 14));
        put_inst(10, enc_jump(word_to_baddr(14)));
        put_inst(14, enc_r(3'd6, 1, 1, 1, 1'b1));       // unused opcode
        put_inst(15, enc_i(OP_STORE, 0, 1, 15));
        put_inst(3, enc_i(OP_STORE, 0, 1, -1));         // skipped words that store if reached
        put_inst(4, enc_i(OP_STORE, 0, 1, -1));
        put_inst(5, enc_i(OP_STORE, 0, 1, -1));
        put_inst(11, enc_i(OP_STORE, 0, 1, -1));
        put_inst(13, enc_i(OP_STORE, 0, 1, -1));
        expect_write(word_to_baddr(14), 16'sd14);
        expect_write(word_to_baddr(15), 16'sd7);
        release_reset();
        run_until(11);
        foreach (exp_pc[i])
            check_addr("inst_addr", fetch_log[i], word_to_baddr(exp_pc[i]));
        check_writes();
    endtask

    initial begin
        rst_n      = 1'b0;
        lfsr       = 32'h7d9d;
        cycle_cnt  = 0;
        wait_left  = 0;
        retire_cnt = 0;
        add_sub_program();
        mult_slt_program();
        neg_imm_program();
        branch_jump_program();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: cpu_core.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/mem_bridge.sv
verilog/cpu_ctrl.sv
verilog/cpu_core.sv
verification/tb_cpu_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run the testbench, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f cpu_core.f --top-module tb_cpu_core \
    -o sim_tb_cpu_core > build.log 2>&1 \
    && ./obj_dir/sim_tb_cpu_core > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "All checks passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
